// File: design/soc_bus_pkg.sv
// Single master data bus types with byte addresses and little endian byte lanes.
`default_nettype none

package soc_bus_pkg;

	localparam int WORD_W = 32;
	localparam int BYTES_W = 4;

	// Held stable by the master until ack or error.
	typedef struct packed {
		logic [WORD_W-1:0]  addr;
		logic [WORD_W-1:0]  wr_val;
		logic [BYTES_W-1:0] bytesel;	// One bit per byte lane.
		logic               wr_en;
	} d_req_t;

	// Ack and error are one cycle pulses and never high together.
	typedef struct packed {
		logic [WORD_W-1:0] data;	// Valid with ack on a read.
		logic              ack;
		logic              error;
	} d_rsp_t;

endpackage

`default_nettype wire

// File: design/soc_map_pkg.sv
// Memory map with 4 KiB regions and UART timing, where ROM_IMAGE is relative to the simulation directory.
`default_nettype none

package soc_map_pkg;

	localparam logic [31:0] RAM_BASE = 32'h0000_0000;
	localparam logic [31:0] ROM_BASE = 32'h1000_0000;
	localparam logic [31:0] UART_BASE = 32'h8000_0000;

	localparam int REGION_SHIFT = 12;
	localparam logic [31:0] REGION_MASK = ~((32'd1 << REGION_SHIFT) - 32'd1);

	localparam int MEM_WORDS = 1024;
	localparam int MEM_AW = $clog2(MEM_WORDS);	// Word index width.

	typedef enum logic [1:0] {
		REG_RAM,
		REG_ROM,
		REG_UART,
		REG_NONE
	} region_e;

	// Offsets inside the UART region.
	localparam logic [REGION_SHIFT-1:0] UART_DATA_OFS = REGION_SHIFT'(0);
	localparam logic [REGION_SHIFT-1:0] UART_STATUS_OFS = REGION_SHIFT'(4);
	localparam int STATUS_TX_READY = 0;
	localparam int STATUS_RX_VALID = 1;

	localparam int UART_CLKS_PER_BIT = 8;
	localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);

	localparam string ROM_IMAGE = "verification/boot_rom.hex";

endpackage

`default_nettype wire

// File: design/data_bus_decode.sv
// Region decode on address bits 31:12 only, so every alias inside a 4 KiB region hits the same target.
`timescale 1ns/1ns
`default_nettype none

module data_bus_decode (
	input  wire                        clk,
	input  wire                        i_rst_n,
	input  wire                        i_d_access,
	input  wire logic [31:0]           i_d_addr,
	input  wire logic [31:0]           i_i_addr,
	input  wire soc_bus_pkg::d_rsp_t   i_ram_rsp,
	input  wire soc_bus_pkg::d_rsp_t   i_rom_rsp,
	input  wire soc_bus_pkg::d_rsp_t   i_uart_rsp,
	input  wire logic [31:0]           i_ram_i_data,
	input  wire logic [31:0]           i_rom_i_data,
	output logic                       o_ram_access,
	output logic                       o_rom_access,
	output logic                       o_uart_access,
	output soc_bus_pkg::d_rsp_t        o_d_rsp,
	output logic [31:0]                o_i_data
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	region_e d_region;
	region_e i_region;
	region_e i_region_q;	// Region of last cycle's fetch.
	logic    none_err;
	d_rsp_t  none_rsp;

	function automatic region_e region_of(input logic [WORD_W-1:0] addr);
		region_e r;
		case (addr & REGION_MASK)
			RAM_BASE:  r = REG_RAM;
			ROM_BASE:  r = REG_ROM;
			UART_BASE: r = REG_UART;
			default:   r = REG_NONE;
		endcase
		return r;
	endfunction

	assign d_region = region_of(i_d_addr);
	assign i_region = region_of(i_i_addr);

	// Only the selected target sees the strobe.
	assign o_ram_access = i_d_access && (d_region == REG_RAM);
	assign o_rom_access = i_d_access && (d_region == REG_ROM);
	assign o_uart_access = i_d_access && (d_region == REG_UART);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			none_err <= 1'b0;
			i_region_q <= REG_NONE;
		end else begin
			none_err <= i_d_access && (d_region == REG_NONE) && !none_err;	// One pulse.
			i_region_q <= i_region;
		end
	end

	assign none_rsp = '{data: '0, ack: 1'b0, error: none_err};

	always_comb begin
		case (d_region)
			REG_RAM:  o_d_rsp = i_ram_rsp;
			REG_ROM:  o_d_rsp = i_rom_rsp;
			REG_UART: o_d_rsp = i_uart_rsp;
			default:  o_d_rsp = none_rsp;
		endcase
	end

	// RAM and ROM fetch data arrive a cycle after the address.
	always_comb begin
		case (i_region_q)
			REG_RAM: o_i_data = i_ram_i_data;
			REG_ROM: o_i_data = i_rom_i_data;
			default: o_i_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: design/onchip_ram.sv
// Address bits above 11 and the two low bits are ignored, and contents are undefined after power up.
`timescale 1ns/1ns
`default_nettype none

module onchip_ram (
	input  wire                       clk,
	input  wire                       i_rst_n,
	input  wire logic [31:0]          i_i_addr,
	input  wire                       i_access,
	input  wire soc_bus_pkg::d_req_t  i_req,
	output logic [31:0]               o_i_data,
	output soc_bus_pkg::d_rsp_t       o_rsp
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [WORD_W-1:0] mem [MEM_WORDS];
	logic [MEM_AW-1:0] i_idx;
	logic [MEM_AW-1:0] d_idx;
	logic [WORD_W-1:0] rd_data;
	logic              ack_q;

	assign i_idx = i_i_addr[2 +: MEM_AW];
	assign d_idx = i_req.addr[2 +: MEM_AW];

	// Fetch port.
	always_ff @(posedge clk) begin
		o_i_data <= mem[i_idx];
	end

	// Data port.
	always_ff @(posedge clk) begin
		if (i_access && !ack_q) begin
			if (i_req.wr_en) begin
				for (int b = 0; b < BYTES_W; b++) begin
					if (i_req.bytesel[b])
						mem[d_idx][8*b +: 8] <= i_req.wr_val[8*b +: 8];
				end
			end
			rd_data <= mem[d_idx];	// Old word on a write.
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= i_access && !ack_q;
	end

	assign o_rsp = '{data: rd_data, ack: ack_q, error: 1'b0};

endmodule

`default_nettype wire

// File: design/boot_rom.sv
// Contents come from ROM_IMAGE at start of simulation only, so synthesis needs a tool that maps the load.
`timescale 1ns/1ns
`default_nettype none

module boot_rom (
	input  wire                       clk,
	input  wire                       i_rst_n,
	input  wire logic [31:0]          i_i_addr,
	input  wire                       i_access,
	input  wire soc_bus_pkg::d_req_t  i_req,
	output logic [31:0]               o_i_data,
	output soc_bus_pkg::d_rsp_t       o_rsp
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [WORD_W-1:0] mem [MEM_WORDS];
	logic [WORD_W-1:0] rd_data;
	logic              ack_q;
	logic              err_q;
	logic              busy;

	initial begin
		$readmemh(ROM_IMAGE, mem);
	end

	always_ff @(posedge clk) begin
		o_i_data <= mem[i_i_addr[2 +: MEM_AW]];
		if (i_access)
			rd_data <= mem[i_req.addr[2 +: MEM_AW]];
	end

	assign busy = ack_q || err_q;	// Response cycle.

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= i_access && !i_req.wr_en && !busy;
			err_q <= i_access && i_req.wr_en && !busy;	// Writes are refused.
		end
	end

	assign o_rsp = '{data: rd_data, ack: ack_q, error: err_q};

endmodule

`default_nettype wire

// File: design/uart_periph.sv
// Fixed 8N1 at UART_CLKS_PER_BIT clocks per bit with no FIFO, so an unread byte is lost to the next one.
`timescale 1ns/1ns
`default_nettype none

module uart_periph (
	input  wire                       clk,
	input  wire                       i_rst_n,
	input  wire                       i_access,
	input  wire soc_bus_pkg::d_req_t  i_req,
	input  wire                       i_rx,
	output soc_bus_pkg::d_rsp_t       o_rsp,
	output logic                      o_tx
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	tx_state_e             tx_state;
	logic [UART_CNT_W-1:0] tx_cnt;
	logic [2:0]            tx_bit;
	logic [7:0]            tx_shift;
	logic                  tx_tick;
	logic                  tx_start;
	rx_state_e             rx_state;
	logic [UART_CNT_W-1:0] rx_cnt;
	logic [2:0]            rx_bit;
	logic [7:0]            rx_shift;
	logic [7:0]            rx_data;
	logic                  rx_meta;
	logic                  rx_s;
	logic                  rx_tick;
	logic                  rx_mid;
	logic                  rx_done;
	logic                  rx_valid;
	logic                  is_data;
	logic                  is_status;
	logic                  wr_data;
	logic                  rd_clear;
	logic                  ack_q;
	logic [WORD_W-1:0]     status;
	logic [WORD_W-1:0]     rd_data;

	assign is_data = i_req.addr[REGION_SHIFT-1:0] == UART_DATA_OFS;
	assign is_status = i_req.addr[REGION_SHIFT-1:0] == UART_STATUS_OFS;
	assign wr_data = is_data && i_req.wr_en;

	// Data writes stall here until the transmitter is idle.
	assign tx_start = i_access && !ack_q && wr_data && (tx_state == TX_IDLE);
	assign rd_clear = i_access && !ack_q && is_data && !i_req.wr_en;

	assign tx_tick = tx_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1);
	assign rx_tick = rx_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1);
	assign rx_mid = rx_cnt == UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1);
	assign rx_done = (rx_state == RX_STOP) && rx_tick && rx_s;	// Good stop bit.

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			tx_state <= TX_IDLE;
			tx_cnt <= '0;
			tx_bit <= '0;
			o_tx <= 1'b1;
		end else begin
			tx_cnt <= (tx_state == TX_IDLE || tx_tick) ? '0 : tx_cnt + 1'b1;
			case (tx_state)
				TX_IDLE: if (tx_start) begin
					tx_state <= TX_START;
					o_tx <= 1'b0;
				end
				TX_START: if (tx_tick) begin
					tx_state <= TX_DATA;
					tx_bit <= '0;
					o_tx <= tx_shift[0];
				end
				TX_DATA: if (tx_tick) begin
					tx_bit <= tx_bit + 1'b1;
					o_tx <= (tx_bit == 3'd7) ? 1'b1 : tx_shift[1];
					if (tx_bit == 3'd7)
						tx_state <= TX_STOP;
				end
				default: if (tx_tick)
					tx_state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta <= i_rx;	// Two flop synchroniser.
			rx_s <= rx_meta;
			rx_cnt <= (rx_state == RX_IDLE || rx_tick) ? '0 : rx_cnt + 1'b1;
			case (rx_state)
				RX_IDLE: if (!rx_s)
					rx_state <= RX_START;
				RX_START: if (rx_mid) begin
					rx_cnt <= '0;	// Realign to mid bit.
					rx_bit <= '0;
					rx_state <= rx_s ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (rx_tick) begin
					rx_bit <= rx_bit + 1'b1;
					if (rx_bit == 3'd7)
						rx_state <= RX_STOP;
				end
				default: if (rx_tick)
					rx_state <= RX_IDLE;
			endcase
			if (rx_done)
				rx_valid <= 1'b1;
			else if (rd_clear)
				rx_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (tx_start)
			tx_shift <= i_req.wr_val[7:0];
		else if (tx_state == TX_DATA && tx_tick)
			tx_shift <= tx_shift >> 1;
		if (rx_state == RX_DATA && rx_tick)
			rx_shift <= {rx_s, rx_shift[7:1]};	// LSB first.
		if (rx_done)
			rx_data <= rx_shift;
	end

	always_comb begin
		status = '0;
		status[STATUS_TX_READY] = tx_state == TX_IDLE;
		status[STATUS_RX_VALID] = rx_valid;
	end

	always_ff @(posedge clk) begin
		if (i_access)
			rd_data <= is_status ? status : (is_data ? {24'b0, rx_data} : '0);
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			ack_q <= 1'b0;
		else
			ack_q <= i_access && !ack_q && (!wr_data || tx_state == TX_IDLE);
	end

	assign o_rsp = '{data: rd_data, ack: ack_q, error: 1'b0};

endmodule

`default_nettype wire

// File: design/soc_top.sv
// Bus fabric only, where the CPU drives the instruction and data ports and must wait for ack or error.
`timescale 1ns/1ns
`default_nettype none

module soc_top (
	input  wire                       clk,
	input  wire                       i_rst_n,
	input  wire logic [31:0]          i_i_addr,
	input  wire                       i_d_access,
	input  wire soc_bus_pkg::d_req_t  i_d_req,
	input  wire                       i_uart_rx,
	output logic [31:0]               o_i_data,
	output soc_bus_pkg::d_rsp_t       o_d_rsp,
	output logic                      o_uart_tx
);

	import soc_bus_pkg::*;

	logic              ram_access;
	logic              rom_access;
	logic              uart_access;
	d_rsp_t            ram_rsp;
	d_rsp_t            rom_rsp;
	d_rsp_t            uart_rsp;
	logic [WORD_W-1:0] ram_i_data;
	logic [WORD_W-1:0] rom_i_data;

	data_bus_decode data_bus_decode_inst (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_d_access    (i_d_access),
		.i_d_addr      (i_d_req.addr),
		.i_i_addr      (i_i_addr),
		.i_ram_rsp     (ram_rsp),
		.i_rom_rsp     (rom_rsp),
		.i_uart_rsp    (uart_rsp),
		.i_ram_i_data  (ram_i_data),
		.i_rom_i_data  (rom_i_data),
		.o_ram_access  (ram_access),
		.o_rom_access  (rom_access),
		.o_uart_access (uart_access),
		.o_d_rsp       (o_d_rsp),
		.o_i_data      (o_i_data)
	);

	onchip_ram onchip_ram_inst (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_i_addr (i_i_addr),
		.i_access (ram_access),
		.i_req    (i_d_req),
		.o_i_data (ram_i_data),
		.o_rsp    (ram_rsp)
	);

	boot_rom boot_rom_inst (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_i_addr (i_i_addr),
		.i_access (rom_access),
		.i_req    (i_d_req),
		.o_i_data (rom_i_data),
		.o_rsp    (rom_rsp)
	);

	uart_periph uart_periph_inst (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_access (uart_access),
		.i_req    (i_d_req),
		.i_rx     (i_uart_rx),
		.o_rsp    (uart_rsp),
		.o_tx     (o_uart_tx)
	);

endmodule

`default_nettype wire

// File: verification/soc_tb.sv
// Run from the project root so that the ROM image loads, with UART transmit looped back to receive.
`timescale 1ns/1ns
`default_nettype none

module soc_tb;

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int SEED = 54576;
	localparam int FRAME_CLKS = 10 * UART_CLKS_PER_BIT;
	localparam int BUS_LIMIT = 2 * FRAME_CLKS;	// Longest legal wait is one frame.

	typedef enum logic [1:0] {K_READ, K_WRITE, K_FETCH} kind_e;

	typedef struct packed {
		kind_e              kind;
		logic [WORD_W-1:0]  addr;
		logic [WORD_W-1:0]  wr_val;
		logic [BYTES_W-1:0] bytesel;
		logic               exp_err;
		logic [WORD_W-1:0]  exp_data;
	} entry_t;

	logic              clk;
	logic              rst_n;
	logic [WORD_W-1:0] fetch_addr;
	logic [WORD_W-1:0] fetch_data;
	logic              d_access;
	d_req_t            d_req;
	d_rsp_t            d_rsp;
	logic              uart_tx;
	entry_t            table_q[$];
	logic [WORD_W-1:0] shadow [bit [WORD_W-1:0]];	// Expected RAM contents.
	logic [7:0]        sent_q[$];
	logic [7:0]        seen_q[$];
	logic              table_done;
	int                value_errs;
	int                proto_errs;

	soc_top soc_top_inst (
		.clk        (clk),
		.i_rst_n    (rst_n),
		.i_i_addr   (fetch_addr),
		.i_d_access (d_access),
		.i_d_req    (d_req),
		.i_uart_rx  (uart_tx),	// Loopback.
		.o_i_data   (fetch_data),
		.o_d_rsp    (d_rsp),
		.o_uart_tx  (uart_tx)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [WORD_W-1:0] exp,
			input logic [WORD_W-1:0] act);
		assert (act === exp) else begin
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			value_errs++;
		end
	endtask

	task automatic report_fault(input string msg);
		$display("%0t ns: %s", $time, msg);
		proto_errs++;
	endtask

	task automatic bus_access(input logic wr, input logic [WORD_W-1:0] addr,
			input logic [WORD_W-1:0] val, input logic [BYTES_W-1:0] bsel,
			output logic err, output logic [WORD_W-1:0] data, output int waited);
		@(negedge clk);
		d_req = '{addr: addr, wr_val: val, bytesel: bsel, wr_en: wr};
		d_access = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!d_rsp.ack && !d_rsp.error && waited < BUS_LIMIT);
		assert (d_rsp.ack || d_rsp.error)
			else report_fault($sformatf("no ack or error for access to %h", addr));
		assert (!(d_rsp.ack && d_rsp.error))
			else report_fault("ack and error were high together");
		err = d_rsp.error;
		data = d_rsp.data;
		d_access = 1'b0;
	endtask

	task automatic fetch(input logic [WORD_W-1:0] addr, output logic [WORD_W-1:0] data);
		@(negedge clk);
		fetch_addr = addr;
		@(negedge clk);
		data = fetch_data;	// One cycle after the address.
	endtask

	function automatic void add_entry(input kind_e kind, input logic [WORD_W-1:0] addr,
			input logic [WORD_W-1:0] val, input logic [BYTES_W-1:0] bsel,
			input logic exp_err, input logic [WORD_W-1:0] exp_data);
		table_q.push_back('{kind, addr, val, bsel, exp_err, exp_data});
	endfunction

	function automatic void ram_write(input logic [WORD_W-1:0] addr,
			input logic [WORD_W-1:0] val, input logic [BYTES_W-1:0] bsel);
		logic [WORD_W-1:0] word;
		word = shadow.exists(addr) ? shadow[addr] : '0;
		for (int b = 0; b < BYTES_W; b++)
			if (bsel[b])
				word[8*b +: 8] = val[8*b +: 8];
		shadow[addr] = word;
		add_entry(K_WRITE, addr, val, bsel, 1'b0, '0);
	endfunction

	task automatic build_table();
		logic [WORD_W-1:0] rom_words [8];
		logic [WORD_W-1:0] ram_addrs [5];
		rom_words = '{32'h0000_0013, 32'hdead_beef, 32'h0bad_f00d, 32'h1234_5678,
			32'hcafe_babe, 32'h8bad_f00d, 32'ha5a5_5a5a, 32'h0f1e_2d3c};	// Copy of the hex file.
		ram_addrs = '{RAM_BASE + 32'h100, RAM_BASE + 32'h104, RAM_BASE + 32'h108,
			RAM_BASE + 32'h10c, RAM_BASE + 32'hffc};
		foreach (ram_addrs[i])
			ram_write(ram_addrs[i], $urandom, 4'hf);
		ram_write(ram_addrs[0], $urandom, 4'b0101);
		ram_write(ram_addrs[1], $urandom, 4'b1000);
		ram_write(ram_addrs[2], $urandom, 4'b0010);
		ram_write(ram_addrs[4], $urandom, 4'b0110);
		foreach (ram_addrs[i])
			add_entry(K_READ, ram_addrs[i], '0, 4'hf, 1'b0, shadow[ram_addrs[i]]);
		foreach (ram_addrs[i])
			add_entry(K_FETCH, ram_addrs[i], '0, '0, 1'b0, shadow[ram_addrs[i]]);
		foreach (rom_words[i])
			add_entry(K_READ, ROM_BASE + 32'(4 * i), '0, 4'hf, 1'b0, rom_words[i]);
		add_entry(K_WRITE, ROM_BASE + 32'h8, $urandom, 4'hf, 1'b1, '0);
		add_entry(K_READ, ROM_BASE + 32'h8, '0, 4'hf, 1'b0, rom_words[2]);
		add_entry(K_FETCH, ROM_BASE, '0, '0, 1'b0, rom_words[0]);
		add_entry(K_FETCH, ROM_BASE + 32'h14, '0, '0, 1'b0, rom_words[5]);
		add_entry(K_FETCH, ROM_BASE + 32'h1c, '0, '0, 1'b0, rom_words[7]);
		add_entry(K_READ, 32'h2000_0000, '0, 4'hf, 1'b1, '0);
		add_entry(K_WRITE, 32'h2000_0000, $urandom, 4'hf, 1'b1, '0);
		add_entry(K_READ, RAM_BASE + 32'h1000, '0, 4'hf, 1'b1, '0);	// Just past the RAM.
		add_entry(K_FETCH, 32'h2000_0000, '0, '0, 1'b0, '0);
		add_entry(K_FETCH, UART_BASE, '0, '0, 1'b0, '0);
		table_done = 1'b1;
	endtask

	task automatic apply_entry(input entry_t e);
		logic              err;
		logic [WORD_W-1:0] data;
		int                waited;
		if (e.kind == K_FETCH) begin
			fetch(e.addr, data);
			check_val($sformatf("o_i_data @%h", e.addr), e.exp_data, data);
		end else begin
			bus_access(e.kind == K_WRITE, e.addr, e.wr_val, e.bytesel, err, data, waited);
			check_val($sformatf("o_d_rsp.error @%h", e.addr), e.exp_err, err);
			if (e.kind == K_READ && !e.exp_err)
				check_val($sformatf("o_d_rsp.data @%h", e.addr), e.exp_data, data);
		end
	endtask

	task automatic send_byte(input logic [7:0] b, output int waited);
		logic              err;
		logic [WORD_W-1:0] data;
		bus_access(1'b1, UART_BASE + UART_DATA_OFS, {24'b0, b}, 4'h1, err, data, waited);
		check_val("o_d_rsp.error uart data write", 1'b0, err);
		sent_q.push_back(b);
	endtask

	task automatic read_rx(input logic [7:0] exp);
		logic              err;
		logic [WORD_W-1:0] data;
		int                waited;
		int                polls;
		polls = 0;
		do begin
			bus_access(1'b0, UART_BASE + UART_STATUS_OFS, '0, 4'hf, err, data, waited);
			polls++;
		end while (!data[STATUS_RX_VALID] && polls < FRAME_CLKS);
		assert (data[STATUS_RX_VALID]) else report_fault("UART receiver never flagged a byte");
		bus_access(1'b0, UART_BASE + UART_DATA_OFS, '0, 4'hf, err, data, waited);
		check_val("o_d_rsp.data uart rx", {24'b0, exp}, data);
		bus_access(1'b0, UART_BASE + UART_STATUS_OFS, '0, 4'hf, err, data, waited);
		check_val("status rx_valid after read", 1'b0, data[STATUS_RX_VALID]);
	endtask

	task automatic run_uart();
		logic [7:0]        b [3];
		logic              err;
		logic [WORD_W-1:0] data;
		int                waited;
		foreach (b[i])
			b[i] = 8'($urandom);
		bus_access(1'b0, UART_BASE + UART_STATUS_OFS, '0, 4'hf, err, data, waited);
		check_val("status tx_ready when idle", 1'b1, data[STATUS_TX_READY]);
		send_byte(b[0], waited);
		read_rx(b[0]);
		send_byte(b[1], waited);
		bus_access(1'b0, UART_BASE + UART_STATUS_OFS, '0, 4'hf, err, data, waited);
		check_val("status tx_ready during frame", 1'b0, data[STATUS_TX_READY]);
		send_byte(b[2], waited);
		// Second write has to sit out the whole first frame.
		assert (waited >= FRAME_CLKS - 4)
			else report_fault($sformatf("UART write acked after %0d cycles while busy", waited));
		read_rx(b[1]);
		read_rx(b[2]);
	endtask

	// Independent 8N1 decoder on the transmit line.
	initial begin
		logic [7:0] rx_byte;
		forever begin
			@(negedge uart_tx);
			repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
			assert (uart_tx == 1'b0) else report_fault("start bit on o_uart_tx too short");
			for (int i = 0; i < 8; i++) begin
				repeat (UART_CLKS_PER_BIT) @(negedge clk);
				rx_byte[i] = uart_tx;
			end
			repeat (UART_CLKS_PER_BIT) @(negedge clk);
			assert (uart_tx == 1'b1) else report_fault("missing stop bit on o_uart_tx");
			seen_q.push_back(rx_byte);
		end
	end

	initial begin
		int limit;
		wait (table_done === 1'b1);
		limit = table_q.size() * 40 + 4 * FRAME_CLKS;
		repeat (limit) @(posedge clk);
		$display("%0t ns: run timed out after %0d cycles", $time, limit);
		$display("sim failed");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		fetch_addr = '0;
		d_access = 1'b0;
		d_req = '0;
		table_done = 1'b0;
		value_errs = 0;
		proto_errs = 0;
		build_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_val("o_d_rsp.ack in reset", 1'b0, d_rsp.ack);
		check_val("o_d_rsp.error in reset", 1'b0, d_rsp.error);
		check_val("o_uart_tx in reset", 1'b1, uart_tx);
		check_val("o_i_data in reset", '0, fetch_data);
		rst_n = 1'b1;
		foreach (table_q[i])
			apply_entry(table_q[i]);
		run_uart();
		repeat (UART_CLKS_PER_BIT) @(negedge clk);
		check_val("o_uart_tx byte count", sent_q.size(), seen_q.size());
		foreach (sent_q[i])
			if (i < seen_q.size())
				check_val("o_uart_tx byte", sent_q[i], seen_q[i]);
		$display("errors: value %0d, protocol %0d", value_errs, proto_errs);
		if (value_errs + proto_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/boot_rom.hex
// One 32-bit word per line in hex, starting at ROM word 0.
00000013
deadbeef
0badf00d
12345678
cafebabe
8badf00d
a5a55a5a
0f1e2d3c

// File: project.f
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/data_bus_decode.sv
design/onchip_ram.sv
design/boot_rom.sv
design/uart_periph.sv
design/soc_top.sv
verification/soc_tb.sv

// File: Bender.yml
package:
  name: soc_bus_fabric

sources:
  - files:
      - design/soc_bus_pkg.sv
      - design/soc_map_pkg.sv
      - design/data_bus_decode.sv
      - design/onchip_ram.sv
      - design/boot_rom.sv
      - design/uart_periph.sv
      - design/soc_top.sv

  - target: test
    files:
      - verification/soc_tb.sv
